// File: verification/arm_trace.txt
# I <instruction hex> <instrReady>, one clock cycle each. W <rd hex> <result hex> in retire order
# F <nzcv binary> gives the flag register after the retirement before it. # starts a comment
I E2801005 1 W 1 00000005             # ADD   r1, r0, #5
I E2812003 1 W 2 00000008             # ADD   r2, r1, #3
I E0813002 0                          # stall
I E0813002 1 W 3 0000000D             # ADD   r3, r1, r2
I E2434001 1 W 4 0000000C             # SUB   r4, r3, #1
I E38450F0 1 W 5 000000FC             # ORR   r5, r4, #0xF0
I E0056003 1 W 6 0000000C             # AND   r6, r5, r3
I E0467004 1 W 7 00000000             # SUB   r7, r6, r4
I E2518005 1 W 8 00000000 F 0110      # SUBS  r8, r1, #5
I 02829001 1 W 9 00000009             # ADDEQ r9, r2, #1
I 12899010 1                          # ADDNE r9, r9, #0x10   skipped
I E051A002 1 W A FFFFFFFD F 1000      # SUBS  r10, r1, r2
I B380B022 0                          # stall
I B380B022 0                          # stall
I B380B022 1 W B 00000022 F 1000      # ORRLT r11, r0, #0x22
I A380B033 1                          # ORRGE r11, r0, #0x33   skipped
I 8280C001 1                          # ADDHI r12, r0, #1   skipped
I 9280C002 1 W C 00000002             # ADDLS r12, r0, #2
I E29AD005 1 W D 00000002 F 0010      # ADDS  r13, r10, #5
I E211E002 1 W E 00000000 F 0110      # ANDS  r14, r1, #2
I 228EE007 0                          # stall
I 228EE007 1 W E 00000007             # ADDCS r14, r14, #7
I 42411001 1                          # SUBMI r1, r1, #1   skipped
I 50811001 1 W 1 0000000A F 0110      # ADDPL r1, r1, r1
I E189300C 1 W 3 0000000B             # ORR   r3, r9, r12

// File: all.f
+incdir+hw
hw/armIsaPkg.sv
hw/armPipePkg.sv
hw/writebackIf.sv
hw/decodeStage.sv
hw/regFile.sv
hw/executeStage.sv
hw/armCore.sv
verification/tbClock.sv
verification/armCore_assertions.sv
verification/armCoreTb.sv

// File: Makefile
SIM  := obj_dir/VarmCoreTb
SRCS := $(wildcard hw/*.sv hw/*.svh verification/*.sv)

$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert --top-module armCoreTb -f all.f

.PHONY: run clean

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// File: verification/armCoreTb.sv
`timescale 1ns/100ps
`include "arm_cfg.svh"

module armCoreTb import armIsaPkg::*; ();

   localparam int    CLK_PERIOD = 40;
   localparam string TRACE_FILE = "verification/arm_trace.txt";
   localparam Word   FILLER     = 32'hE380_0000;   // ORR r0, r0, #0

   typedef struct packed
   {
      RegAddr rd;
      Word    result;
      logic   hasFlags;
      Flags   flags;
   } Retire;

   logic   clk;
   logic   reset;
   logic   instrReady;
   Word    instrF;
   Word    pcF;
   logic   wbValid;
   RegAddr wbRd;
   Word    wbResult;
   Flags   flags;

   Word         stimInstr [$];
   logic        stimReady [$];
   Retire       expected [$];
   int          stallCycles = 0;
   int          accepted = 0;     // rising edges with instrReady high
   int          retired = 0;
   bit          traceLoaded = 1'b0;
   logic [31:0] rngState;

   tbClock #(.PERIOD(CLK_PERIOD)) clk0 (.clk(clk), .reset(reset));

   armCore dut0
   (
      .clk        (clk),
      .reset      (reset),
      .instrReady (instrReady),
      .instrF     (instrF),
      .pcF        (pcF),
      .wbValid    (wbValid),
      .wbRd       (wbRd),
      .wbResult   (wbResult),
      .flags      (flags)
   );

   bind armCore armCoreAssertions asrt0
   (
      .clk        (clk),
      .reset      (reset),
      .instrReady (instrReady),
      .pcF        (pcF),
      .wbValid    (wbValid)
   );

   function automatic logic [31:0] lcgNext(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic abortRun(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic checkWord(input string name, input Word exp, input Word act);
      if (act !== exp)
         abortRun($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic checkReg(input string name, input RegAddr exp, input RegAddr act);
      if (act !== exp)
         abortRun($sformatf("Mismatch %s: expected r%0d, actual r%0d", name, exp, act));
   endtask

   task automatic checkFlags(input string name, input Flags exp, input Flags act);
      if (act !== exp)
         abortRun($sformatf("Mismatch %s: expected nzcv %b, actual nzcv %b", name, exp, act));
   endtask

   // Records are read token by token, # skips the rest of a line
   task automatic loadTrace();
      int         fd;
      int         code;
      byte        kind;
      Word        instr;
      int         ready;
      RegAddr     rd;
      Word        value;
      logic [3:0] nzcv;
      string      rest;
      Retire      r;
      fd = $fopen(TRACE_FILE, "r");
      if (fd == 0)
         abortRun("Cannot open the trace file");
      while (!$feof(fd))
      begin
         code = $fscanf(fd, " %c", kind);
         if (code != 1)
            break;
         case (kind)
            "#": code = $fgets(rest, fd);
            "I":
            begin
               code = $fscanf(fd, "%h %d", instr, ready);
               stimInstr.push_back(instr);
               stimReady.push_back(ready != 0);
               if (ready == 0)
                  stallCycles++;
            end
            "W":
            begin
               code = $fscanf(fd, "%h %h", rd, value);
               r = '{rd: rd, result: value, hasFlags: 1'b0, flags: '0};
               expected.push_back(r);
            end
            "F":
            begin
               code = $fscanf(fd, "%b", nzcv);
               if (expected.size() == 0)
                  abortRun("Flag record in the trace before any retirement record");
               r = expected.pop_back();
               r.hasFlags = 1'b1;
               r.flags = Flags'(nzcv);
               expected.push_back(r);
            end
            default: abortRun($sformatf("Unknown record type %c in the trace", kind));
         endcase
      end
      $fclose(fd);
   endtask

   // Outputs settle after the rising edge, so they are read at the falling one
   task automatic checkCycle();
      Retire r;
      checkWord("pcF", Word'(`RESET_PC) + Word'(accepted * `PC_STEP), pcF);
      if (wbValid)
      begin
         if (expected.size() == 0)
            abortRun("A retirement appeared that the trace does not list");
         r = expected.pop_front();
         checkReg($sformatf("retirement %0d wbRd", retired), r.rd, wbRd);
         checkWord($sformatf("retirement %0d wbResult", retired), r.result, wbResult);
         if (r.hasFlags)
            checkFlags($sformatf("retirement %0d flags", retired), r.flags, flags);
         retired++;
      end
   endtask

   always @(posedge clk)
   begin
      if (!reset && instrReady)
         accepted <= accepted + 1;
   end

   initial
   begin : stimulus
      logic fillReady;
      instrReady = 1'b0;
      instrF     = '0;
      rngState   = 32'h2d00_9a8c;
      loadTrace();
      traceLoaded = 1'b1;
      @(negedge reset);   // falls together with the clock
      checkWord("pcF after reset", Word'(`RESET_PC), pcF);
      checkFlags("flags after reset", '0, flags);
      if (wbValid !== 1'b0)
         abortRun("wbValid is high right after reset");
      for (int i = 0; i < stimInstr.size(); i++)
      begin
         instrF     = stimInstr[i];
         instrReady = stimReady[i];
         @(negedge clk);
         checkCycle();
      end
      // Drain, a low filler cycle is always followed by a high one
      fillReady = 1'b1;
      while (expected.size() != 0)
      begin
         rngState   = lcgNext(rngState);
         fillReady  = rngState[31] | ~fillReady;
         instrF     = FILLER;
         instrReady = fillReady;
         @(negedge clk);
         checkCycle();
      end
      $display("Simulation PASSED");
      $finish;
   end

   initial
   begin : watchdog
      int limitCycles;
      wait (traceLoaded);
      limitCycles = (stimInstr.size() - stallCycles) + stallCycles + 10;
      #(limitCycles * CLK_PERIOD);
      abortRun($sformatf("Timeout after %0d cycles with %0d retirements still missing",
                         limitCycles, expected.size()));
   end

endmodule

// File: verification/armCore_assertions.sv
`timescale 1ns/100ps

module armCoreAssertions import armIsaPkg::*;
(
   input logic clk,
   input logic reset,
   input logic instrReady,
   input Word  pcF,
   input logic wbValid
);

   // Nothing retires in the first cycle out of reset
   property quietAfterReset;
      @(posedge clk) $fell(reset) |=> !wbValid;
   endproperty

   property pcHeldWhenFrozen;
      @(posedge clk) disable iff (reset) !instrReady |=> $stable(pcF);
   endproperty

   // A frozen edge loads no new retirement
   property noRetireWhenFrozen;
      @(posedge clk) disable iff (reset) !instrReady |=> !wbValid;
   endproperty

   assert property (quietAfterReset)
      else $error("wbValid high in the first cycle after reset");
   assert property (pcHeldWhenFrozen)
      else $error("pcF moved on an edge with instrReady low");
   assert property (noRetireWhenFrozen)
      else $error("wbValid raised by an edge with instrReady low");

endmodule

// File: verification/tbClock.sv
`timescale 1ns/100ps

module tbClock
#(
   parameter int PERIOD = 40
)
(
   output logic clk,
   output logic reset
);

   initial
   begin
      clk   = 1'b0;
      reset = 1'b1;
      repeat (2) @(posedge clk);   // two rising edges in reset
      @(negedge clk);
      reset = 1'b0;
   end

   always #(PERIOD/2) clk = ~clk;

endmodule

// File: hw/armCore.sv
`timescale 1ns/100ps

module armCore import armIsaPkg::*, armPipePkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  logic   instrReady,   // freezes every stage when low
   input  Word    instrF,
   output Word    pcF,
   output logic   wbValid,
   output RegAddr wbRd,
   output Word    wbResult,
   output Flags   flags
);

   RegAddr   rn;
   RegAddr   rm;
   Word      rdA;
   Word      rdB;
   DecodedOp decOp;   // decode/execute boundary

   writebackIf wb0 ();

   decodeStage dec0
   (
      .clk        (clk),
      .reset      (reset),
      .instrReady (instrReady),
      .instrF     (instrF),
      .pcF        (pcF),
      .rn         (rn),
      .rm         (rm),
      .rdA        (rdA),
      .rdB        (rdB),
      .op         (decOp)
   );

   regFile rf0
   (
      .clk   (clk),
      .reset (reset),
      .wb    (wb0),
      .rn    (rn),
      .rm    (rm),
      .rdA   (rdA),
      .rdB   (rdB)
   );

   executeStage ex0
   (
      .clk        (clk),
      .reset      (reset),
      .instrReady (instrReady),
      .op         (decOp),
      .wb         (wb0),
      .flags      (flags)
   );

   // One pulse per retirement, never repeated while frozen
   assign wbValid  = wb0.fresh;
   assign wbRd     = wb0.rd;
   assign wbResult = wb0.result;

endmodule

// File: hw/executeStage.sv
`timescale 1ns/100ps
`include "arm_cfg.svh"

module executeStage import armIsaPkg::*, armPipePkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       instrReady,
   input  DecodedOp   op,
   writebackIf.source wb,
   output Flags       flags
);

   FwdSel              fwdA;
   FwdSel              fwdB;
   Word                srcA;
   Word                regB;
   Word                srcB;
   Word                condInvB;
   Word                result;
   logic [`DATA_WIDTH:0] sum;   // carry out on top
   logic               arith;
   logic               condPass;
   logic               retire;
   Flags               aluFlags;
   Flags               flagsNext;

   // Only the writeback register can be newer than the decode read
   assign fwdA = (wb.valid && (wb.rd == op.rn)) ? FROM_WB : NONE;
   assign fwdB = (wb.valid && (wb.rd == op.rm)) ? FROM_WB : NONE;

   assign srcA = (fwdA == FROM_WB) ? wb.result : op.srcA;
   assign regB = (fwdB == FROM_WB) ? wb.result : op.srcB;
   assign srcB = op.useImm ? op.imm : regB;

   // Shared adder, SUB adds the inverse plus one
   assign arith    = ~op.aluOp[1];
   assign condInvB = op.aluOp[0] ? ~srcB : srcB;
   assign sum      = {1'b0, srcA} + {1'b0, condInvB} + {{`DATA_WIDTH{1'b0}}, op.aluOp[0]};

   always_comb
   begin
      case (op.aluOp)
         AND:     result = srcA & srcB;
         ORR:     result = srcA | srcB;
         default: result = sum[`DATA_WIDTH-1:0];
      endcase
   end

   assign aluFlags.n = result[`DATA_WIDTH-1];
   assign aluFlags.z = (result == '0);
   assign aluFlags.c = arith & sum[`DATA_WIDTH];
   assign aluFlags.v = arith & ~(srcA[`DATA_WIDTH-1] ^ srcB[`DATA_WIDTH-1] ^ op.aluOp[0])
                       & (srcA[`DATA_WIDTH-1] ^ sum[`DATA_WIDTH-1]);

   // Condition against the flag register
   always_comb
   begin
      case (op.cond)
         EQ:      condPass = flags.z;
         NE:      condPass = ~flags.z;
         CS:      condPass = flags.c;
         CC:      condPass = ~flags.c;
         MI:      condPass = flags.n;
         PL:      condPass = ~flags.n;
         VS:      condPass = flags.v;
         VC:      condPass = ~flags.v;
         HI:      condPass = flags.c & ~flags.z;
         LS:      condPass = ~flags.c | flags.z;
         GE:      condPass = (flags.n == flags.v);
         LT:      condPass = (flags.n != flags.v);
         GT:      condPass = ~flags.z & (flags.n == flags.v);
         LE:      condPass = flags.z | (flags.n != flags.v);
         AL:      condPass = 1'b1;
         default: condPass = 1'b0;
      endcase
   end

   assign retire = op.valid & condPass;

   // N and Z on any S op, C and V only from the adder
   always_comb
   begin
      flagsNext = flags;
      if (retire && op.setFlags)
      begin
         flagsNext.n = aluFlags.n;
         flagsNext.z = aluFlags.z;
         if (arith)
         begin
            flagsNext.c = aluFlags.c;
            flagsNext.v = aluFlags.v;
         end
      end
   end

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         flags    <= '0;
         wb.valid <= 1'b0;
         wb.fresh <= 1'b0;
      end
      else if (instrReady)
      begin
         flags    <= flagsNext;
         wb.valid <= retire;
         wb.fresh <= retire;
      end
      else
         wb.fresh <= 1'b0;   // entry held, still forwarded
   end

   // Writeback payload
   always_ff @(posedge clk)
   begin
      if (instrReady && retire)
      begin
         wb.rd     <= op.rd;
         wb.result <= result;
      end
   end

endmodule

// File: hw/regFile.sv
`timescale 1ns/100ps
`include "arm_cfg.svh"

module regFile import armIsaPkg::*;
(
   input  logic   clk,
   input  logic   reset,
   writebackIf.sink wb,
   input  RegAddr rn,
   input  RegAddr rm,
   output Word    rdA,
   output Word    rdB
);

   Word regs [`REG_COUNT];

   // Write on the falling edge
   // Decode reads the new value in the second half of the same cycle
   always_ff @(negedge clk, posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < `REG_COUNT; i++)
            regs[i] <= '0;
      end
      else if (wb.valid && (wb.rd < RegAddr'(`REG_COUNT)))
         regs[wb.rd] <= wb.result;   // rewrite of a held entry is harmless
   end

   // Two asynchronous read ports
   assign rdA = (rn < RegAddr'(`REG_COUNT)) ? regs[rn] : '0;
   assign rdB = (rm < RegAddr'(`REG_COUNT)) ? regs[rm] : '0;

endmodule

// File: hw/decodeStage.sv
`timescale 1ns/100ps
`include "arm_cfg.svh"

module decodeStage import armIsaPkg::*, armPipePkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     instrReady,
   input  Word      instrF,
   output Word      pcF,
   output RegAddr   rn,
   output RegAddr   rm,
   input  Word      rdA,
   input  Word      rdB,
   output DecodedOp op
);

   Word      instrD;
   logic     instrValid;   // instrD holds a fetched instruction
   AluOp     aluOp;
   DecodedOp opNext;

   // PC and fetch valid
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         pcF        <= Word'(`RESET_PC);
         instrValid <= 1'b0;
      end
      else if (instrReady)
      begin
         pcF        <= pcF + Word'(`PC_STEP);
         instrValid <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (instrReady)
         instrD <= instrF;
   end

   // cmd field to ALU op
   always_comb
   begin
      case (instrD[`CMD_POS +: `CMD_WIDTH])
         4'b0100: aluOp = ADD;
         4'b0010: aluOp = SUB;
         4'b0000: aluOp = AND;
         4'b1100: aluOp = ORR;
         default: aluOp = ADD;   // outside the subset
      endcase
   end

   // Read request goes out combinationally
   assign rn = instrD[`RN_POS +: `REG_ADDR_WIDTH];
   assign rm = instrD[`RM_POS +: `REG_ADDR_WIDTH];

   always_comb
   begin
      opNext.valid    = instrValid;
      opNext.aluOp    = aluOp;
      opNext.cond     = CondCode'(instrD[`COND_POS +: `COND_WIDTH]);
      opNext.setFlags = instrD[`S_BIT];
      opNext.useImm   = instrD[`IMM_BIT];
      opNext.imm      = Word'(instrD[`IMM_WIDTH-1:0]);   // zero extended
      opNext.rn       = rn;
      opNext.rm       = rm;
      opNext.rd       = instrD[`RD_POS +: `REG_ADDR_WIDTH];
      opNext.srcA     = rdA;
      opNext.srcB     = rdB;
   end

   // Sampled after the mid-cycle write, so a result two ahead is already seen
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         op <= '0;
      else if (instrReady)
         op <= opNext;
   end

endmodule

// File: hw/writebackIf.sv
`timescale 1ns/100ps

// Retiring result, from the writeback register to the register file
interface writebackIf import armIsaPkg::*; ();

   logic   valid;    // entry holds a retired result
   logic   fresh;    // entry was loaded at the last edge
   RegAddr rd;
   Word    result;

   modport source
   (
      output valid,
      output fresh,
      output rd,
      output result
   );

   // Register file write port
   modport sink
   (
      input valid,
      input rd,
      input result
   );

endinterface

// File: hw/armPipePkg.sv
package armPipePkg;

   import armIsaPkg::*;

   // Contents of the decode/execute boundary register
   typedef struct packed
   {
      logic    valid;
      AluOp    aluOp;
      CondCode cond;
      logic    setFlags;   // S bit
      logic    useImm;     // second operand from imm
      Word     imm;
      RegAddr  rn;
      RegAddr  rm;
      RegAddr  rd;
      Word     srcA;       // Rn as read at decode
      Word     srcB;       // Rm as read at decode
   } DecodedOp;

   // Operand source in execute
   typedef enum logic
   {
      NONE    = 1'b0,
      FROM_WB = 1'b1
   } FwdSel;

endpackage

// File: hw/armIsaPkg.sv
`include "arm_cfg.svh"

package armIsaPkg;

   typedef logic [`DATA_WIDTH-1:0]     Word;
   typedef logic [`REG_ADDR_WIDTH-1:0] RegAddr;

   // Bit 0 selects subtract, bit 1 selects the logic ops
   typedef enum logic [1:0]
   {
      ADD = 2'b00,
      SUB = 2'b01,
      AND = 2'b10,
      ORR = 2'b11
   } AluOp;

   // Condition field of every instruction
   typedef enum logic [3:0]
   {
      EQ = 4'b0000,   // Z set
      NE = 4'b0001,
      CS = 4'b0010,   // C set
      CC = 4'b0011,
      MI = 4'b0100,   // N set
      PL = 4'b0101,
      VS = 4'b0110,   // V set
      VC = 4'b0111,
      HI = 4'b1000,   // unsigned higher
      LS = 4'b1001,
      GE = 4'b1010,   // N == V
      LT = 4'b1011,
      GT = 4'b1100,
      LE = 4'b1101,
      AL = 4'b1110
   } CondCode;

   // Status flags, NZCV from the top bit down
   typedef struct packed
   {
      logic n;
      logic z;
      logic c;
      logic v;
   } Flags;

endpackage

// File: hw/arm_cfg.svh
`ifndef ARM_CFG_SVH
`define ARM_CFG_SVH

// Datapath sizes
`define DATA_WIDTH     32
`define REG_ADDR_WIDTH 4
`define REG_COUNT      15   // R0..R14, R15 is never named

// Fetch
`define PC_STEP        4
`define RESET_PC       0

// Data-processing encoding
`define IMM_WIDTH      8    // zero-extended immed_8
`define COND_POS       28
`define COND_WIDTH     4
`define IMM_BIT        25   // 1 = immediate form
`define CMD_POS        21
`define CMD_WIDTH      4
`define S_BIT          20
`define RN_POS         16
`define RD_POS         12
`define RM_POS         0

`endif
